//--- rtl/uart_bridge_pkg.sv
package uart_bridge_pkg;

    // One host frame, command byte then data byte
    typedef struct packed {
        logic [7:0] cmd;
        logic [7:0] data;
    } cmd_frame_t;

    // Memory-controller command channel
    typedef struct packed {
        logic        en;        // One-cycle strobe
        logic        rw;        // 1 = read
        logic [29:0] byte_addr;
    } mem_cmd_t;

    // Write-data channel into the holding register
    typedef struct packed {
        logic        en;
        logic [3:0]  mask;      // 1 = byte is written
        logic [31:0] data;
    } mem_wr_t;

    // Return a byte of the debug register
    localparam logic [7:0] OP_RD_BYTE0  = 8'h10;
    localparam logic [7:0] OP_RD_BYTE1  = 8'h11;
    localparam logic [7:0] OP_RD_BYTE2  = 8'h12;
    localparam logic [7:0] OP_RD_BYTE3  = 8'h13;

    // Byte address, byte at a time
    localparam logic [7:0] OP_ADDR0     = 8'h20;
    localparam logic [7:0] OP_ADDR1     = 8'h21;
    localparam logic [7:0] OP_ADDR2     = 8'h22;
    localparam logic [7:0] OP_ADDR3     = 8'h23;

    // Write data, byte at a time
    localparam logic [7:0] OP_WDATA0    = 8'h24;
    localparam logic [7:0] OP_WDATA1    = 8'h25;
    localparam logic [7:0] OP_WDATA2    = 8'h26;
    localparam logic [7:0] OP_WDATA3    = 8'h27;

    localparam logic [7:0] OP_MASK      = 8'h31;
    localparam logic [7:0] OP_MEM_READ  = 8'h50;
    localparam logic [7:0] OP_MEM_WRITE = 8'h51;

    localparam int CLKS_PER_BIT_DEFAULT = 16;

endpackage

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       rxd,
    output logic       rx_valid,
    output logic [7:0] rx_data
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic [1:0]       rxd_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_reg;

    wire rxd_s = rxd_sync[1];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rxd_sync  <= 2'b11;     // Line idles high
            state     <= RX_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            shift_reg <= '0;
            rx_valid  <= 1'b0;
            rx_data   <= '0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_s)
                        state <= RX_START;
                end
                RX_START: begin
                    if (clk_cnt == HALF_CNT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch shorter than half a bit goes back to idle
                        state   <= rxd_s ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == FULL_CNT) begin
                        clk_cnt   <= '0;
                        shift_reg <= {rxd_s, shift_reg[7:1]};   // LSB first
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == FULL_CNT) begin
                        if (rxd_s) begin    // Bad stop bit drops the byte
                            rx_valid <= 1'b1;
                            rx_data  <= shift_reg;
                        end
                        state <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       tx_req,
    input  logic [7:0] tx_byte,
    output logic       tx_ack,
    output logic       txd
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP,
        TX_ACK
    } tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_reg;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= TX_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            shift_reg <= '0;
            tx_ack    <= 1'b0;
            txd       <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    if (tx_req) begin
                        shift_reg <= tx_byte;
                        txd       <= 1'b0;      // Start bit
                        state     <= TX_START;
                    end
                end
                TX_START: begin
                    if (clk_cnt == FULL_CNT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        txd     <= shift_reg[0];
                        state   <= TX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (clk_cnt == FULL_CNT) begin
                        clk_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            txd   <= 1'b1;      // Stop bit
                            state <= TX_STOP;
                        end else begin
                            bit_idx   <= bit_idx + 1'b1;
                            shift_reg <= {1'b0, shift_reg[7:1]};
                            txd       <= shift_reg[1];
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (clk_cnt == FULL_CNT) begin
                        tx_ack <= 1'b1;
                        state  <= TX_ACK;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                TX_ACK: begin
                    // Hold ack until the requester lets go
                    if (!tx_req) begin
                        tx_ack <= 1'b0;
                        state  <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/cmd_framer.sv
`timescale 1ns/1ps

module cmd_framer import uart_bridge_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    output logic       frame_valid,
    output cmd_frame_t frame
);

    logic       pending;    // Command byte held, waiting for data
    logic [7:0] cmd_hold;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending     <= 1'b0;
            cmd_hold    <= '0;
            frame_valid <= 1'b0;
            frame       <= '0;
        end else begin
            frame_valid <= 1'b0;
            if (rx_valid) begin
                if (!pending) begin
                    // Zero in command slot is the resync byte
                    if (rx_data != 8'h00) begin
                        cmd_hold <= rx_data;
                        pending  <= 1'b1;
                    end
                end else begin
                    pending     <= 1'b0;
                    frame_valid <= 1'b1;
                    frame.cmd   <= cmd_hold;
                    frame.data  <= rx_data;
                end
            end
        end
    end

endmodule

//--- rtl/bridge_ctrl.sv
`timescale 1ns/1ps

module bridge_ctrl import uart_bridge_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        frame_valid,
    input  cmd_frame_t  frame,
    output logic        tx_req,
    output logic [7:0]  tx_byte,
    input  logic        tx_ack,
    output mem_cmd_t    mem_cmd,
    output mem_wr_t     mem_wr,
    input  logic [31:0] rd_data,
    input  logic        rd_empty,
    output logic        rd_en
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_WR_STROBE,
        S_WR_GAP,
        S_WR_CMD,
        S_RD_CMD,
        S_RD_WAIT,
        S_RD_POP,
        S_TX_WAIT,
        S_TX_DONE
    } ctrl_state_t;

    ctrl_state_t state;
    logic [31:0] debug_data;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= S_IDLE;
            mem_cmd    <= '0;
            mem_wr     <= '0;
            rd_en      <= 1'b0;
            tx_req     <= 1'b0;
            tx_byte    <= '0;
            debug_data <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (frame_valid) begin
                        case (frame.cmd)
                            OP_ADDR0:  mem_cmd.byte_addr[7:0]   <= frame.data;
                            OP_ADDR1:  mem_cmd.byte_addr[15:8]  <= frame.data;
                            OP_ADDR2:  mem_cmd.byte_addr[23:16] <= frame.data;
                            OP_ADDR3:  mem_cmd.byte_addr[29:24] <= frame.data[5:0];
                            OP_WDATA0: mem_wr.data[7:0]   <= frame.data;
                            OP_WDATA1: mem_wr.data[15:8]  <= frame.data;
                            OP_WDATA2: mem_wr.data[23:16] <= frame.data;
                            OP_WDATA3: mem_wr.data[31:24] <= frame.data;
                            OP_MASK:   mem_wr.mask <= frame.data[3:0];
                            OP_MEM_WRITE: begin
                                mem_wr.en <= 1'b1;
                                state     <= S_WR_STROBE;
                            end
                            OP_MEM_READ: begin
                                mem_cmd.en <= 1'b1;
                                mem_cmd.rw <= 1'b1;
                                state      <= S_RD_CMD;
                            end
                            OP_RD_BYTE0, OP_RD_BYTE1, OP_RD_BYTE2, OP_RD_BYTE3: begin
                                tx_byte <= debug_data[8*frame.cmd[1:0] +: 8];
                                tx_req  <= 1'b1;
                                state   <= S_TX_WAIT;
                            end
                            default: ;      // Burst length and unknowns do nothing
                        endcase
                    end
                end
                S_WR_STROBE: begin
                    mem_wr.en <= 1'b0;
                    state     <= S_WR_GAP;
                end
                S_WR_GAP: begin             // Idle cycle between data and command
                    mem_cmd.en <= 1'b1;
                    mem_cmd.rw <= 1'b0;
                    state      <= S_WR_CMD;
                end
                S_WR_CMD: begin
                    mem_cmd.en <= 1'b0;
                    state      <= S_IDLE;
                end
                S_RD_CMD: begin
                    mem_cmd.en <= 1'b0;
                    state      <= S_RD_WAIT;
                end
                S_RD_WAIT: begin
                    if (!rd_empty) begin
                        rd_en      <= 1'b1;
                        debug_data <= rd_data;
                        state      <= S_RD_POP;
                    end
                end
                S_RD_POP: begin
                    rd_en <= 1'b0;
                    state <= S_IDLE;
                end
                S_TX_WAIT: begin
                    if (tx_ack) begin
                        tx_req <= 1'b0;
                        state  <= S_TX_DONE;
                    end
                end
                S_TX_DONE: begin
                    // Wait for ack to drop before taking frames again
                    if (!tx_ack)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/mem_port.sv
`timescale 1ns/1ps

module mem_port import uart_bridge_pkg::*; #(
    parameter int ADDR_WORDS_LOG2 = 8
) (
    input  logic        clk,
    input  logic        reset_n,
    input  mem_cmd_t    mem_cmd,
    input  mem_wr_t     mem_wr,
    input  logic        rd_en,
    output logic [31:0] rd_data,
    output logic        rd_empty
);

    localparam int DEPTH = 1 << ADDR_WORDS_LOG2;

    logic [31:0] ram [0:DEPTH-1];
    logic [31:0] wr_hold_data;      // One-entry write-data holding register
    logic [3:0]  wr_hold_mask;
    logic        rd_pend;           // RAM read in flight
    logic [31:0] rd_pend_data;
    logic [31:0] rd_queue [0:1];
    logic        q_wr_ptr;
    logic        q_rd_ptr;
    logic [1:0]  q_count;

    wire [ADDR_WORDS_LOG2-1:0] word_idx = mem_cmd.byte_addr[ADDR_WORDS_LOG2+1:2];
    wire q_pop  = rd_en && (q_count != 2'd0);
    wire q_push = rd_pend && (q_count != 2'd2);

    initial begin
        for (int i = 0; i < DEPTH; i++)
            ram[i] = '0;
    end

    always_ff @(posedge clk) begin
        if (mem_wr.en) begin
            wr_hold_data <= mem_wr.data;
            wr_hold_mask <= mem_wr.mask;
        end
        if (mem_cmd.en && !mem_cmd.rw) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_hold_mask[b])
                    ram[word_idx][8*b +: 8] <= wr_hold_data[8*b +: 8];
            end
        end
        if (mem_cmd.en && mem_cmd.rw)
            rd_pend_data <= ram[word_idx];
        if (q_push)
            rd_queue[q_wr_ptr] <= rd_pend_data;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_pend  <= 1'b0;
            q_wr_ptr <= 1'b0;
            q_rd_ptr <= 1'b0;
            q_count  <= '0;
        end else begin
            rd_pend <= mem_cmd.en && mem_cmd.rw;
            if (q_push)
                q_wr_ptr <= ~q_wr_ptr;
            if (q_pop)
                q_rd_ptr <= ~q_rd_ptr;
            case ({q_push, q_pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: ;
            endcase
        end
    end

    assign rd_data  = rd_queue[q_rd_ptr];   // Head of queue, shown ahead of pop
    assign rd_empty = (q_count == 2'd0);

endmodule

//--- rtl/uart_mem_bridge.sv
`timescale 1ns/1ps

module uart_mem_bridge import uart_bridge_pkg::*; #(
    parameter int CLKS_PER_BIT    = CLKS_PER_BIT_DEFAULT,
    parameter int ADDR_WORDS_LOG2 = 8
) (
    input  logic clk,
    input  logic reset_n,
    input  logic uart_rxd,
    output logic uart_txd
);

    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        frame_valid;
    cmd_frame_t  frame;
    logic        tx_req;
    logic [7:0]  tx_byte;
    logic        tx_ack;
    mem_cmd_t    mem_cmd;
    mem_wr_t     mem_wr;
    logic [31:0] rd_data;
    logic        rd_empty;
    logic        rd_en;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk, .reset_n, .rxd(uart_rxd), .rx_valid, .rx_data
    );

    cmd_framer u_framer (
        .clk, .reset_n, .rx_valid, .rx_data, .frame_valid, .frame
    );

    bridge_ctrl u_ctrl (
        .clk, .reset_n, .frame_valid, .frame,
        .tx_req, .tx_byte, .tx_ack,
        .mem_cmd, .mem_wr, .rd_data, .rd_empty, .rd_en
    );

    mem_port #(.ADDR_WORDS_LOG2(ADDR_WORDS_LOG2)) u_mem (
        .clk, .reset_n, .mem_cmd, .mem_wr, .rd_en, .rd_data, .rd_empty
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk, .reset_n, .tx_req, .tx_byte, .tx_ack, .txd(uart_txd)
    );

endmodule

//--- verification/uart_mem_bridge_chk.sv
`timescale 1ns/1ps

module uart_mem_bridge_chk import uart_bridge_pkg::*; (
    input logic       clk,
    input logic       reset_n,
    input logic       tx_req,
    input logic [7:0] tx_byte,
    input logic       tx_ack,
    input mem_cmd_t   mem_cmd,
    input logic       rd_en,
    input logic       rd_empty
);

    a_tx_byte_stable: assert property (@(posedge clk) disable iff (!reset_n)
        tx_req && $past(tx_req) |-> $stable(tx_byte))
        else $error("tx_byte changed while tx_req was high");

    // Four-phase order, req only drops after ack
    a_req_waits_ack: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(tx_req) |-> $past(tx_ack))
        else $error("tx_req fell before tx_ack was seen");

    a_cmd_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        mem_cmd.en |=> !mem_cmd.en)
        else $error("mem_cmd strobe held longer than one cycle");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
        !(rd_en && rd_empty))
        else $error("rd_en raised while read queue empty");

endmodule

//--- verification/tb_uart_mem_bridge.sv
`timescale 1ns/1ps

module tb_uart_mem_bridge
    import uart_bridge_pkg::*;
();

    localparam int CLKS_PER_BIT    = 16;
    localparam int ADDR_WORDS_LOG2 = 8;
    localparam int DEPTH           = 1 << ADDR_WORDS_LOG2;
    localparam int MAX_PATS        = 64;
    localparam int START_TIMEOUT   = 2000;     // Cycles to wait for a start bit

    localparam logic [31:0] KIND_WRITE   = 32'h1;
    localparam logic [31:0] KIND_READ    = 32'h2;
    localparam logic [31:0] KIND_GARBAGE = 32'h3;
    localparam logic [31:0] KIND_RANDOM  = 32'h4;

    logic        clk;
    logic        reset_n;
    logic        uart_rxd;
    logic        uart_txd;
    logic [31:0] pat_mem [0:MAX_PATS*5-1];
    logic [31:0] shadow [0:DEPTH-1];
    logic [31:0] last_addr;       // Byte address last loaded into the DUT
    integer      seed;
    int          checks;
    int          value_errors;
    int          timeouts;
    int          pattern_errors;
    logic        tx_expected;     // A returned byte has been requested
    logic        txd_reported;

    uart_mem_bridge #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .ADDR_WORDS_LOG2(ADDR_WORDS_LOG2)
    ) u_dut (
        .clk, .reset_n, .uart_rxd, .uart_txd
    );

    bind bridge_ctrl uart_mem_bridge_chk u_chk (
        .clk, .reset_n, .tx_req, .tx_byte, .tx_ack, .mem_cmd, .rd_en, .rd_empty
    );

    always #50 clk = ~clk;

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("ERROR: %s got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("ERROR: %s got 0x%01h, expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic drive_bit(input logic value);
        @(posedge clk);
        #1 uart_rxd = value;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] value);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++)
            drive_bit(value[i]);    // LSB first
        drive_bit(1'b1);
    endtask

    task automatic send_frame(input logic [7:0] cmd, input logic [7:0] data);
        send_byte(cmd);
        send_byte(data);
    endtask

    task automatic receive_byte(output logic [7:0] value, output logic ok);
        int wait_cycles;
        value = '0;
        ok = 1'b0;
        wait_cycles = 0;
        while (uart_txd !== 1'b0 && wait_cycles < START_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (uart_txd !== 1'b0) begin
            timeouts++;
            $display("Timeout: no start bit on uart_txd within %0d cycles", START_TIMEOUT);
        end else begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Middle of start bit
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                value[i] = uart_txd;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_bit("uart_txd stop bit", uart_txd, 1'b1);
            ok = 1'b1;
        end
    endtask

    task automatic request_byte(input int index, input logic [7:0] exp);
        logic [7:0] got;
        logic       ok;
        tx_expected = 1'b1;
        fork
            send_frame(OP_RD_BYTE0 + 8'(index), 8'h00);
            receive_byte(got, ok);
        join
        tx_expected = 1'b0;
        if (ok)
            check_byte($sformatf("uart_txd byte %0d", index), got, exp);
    endtask

    task automatic load_address(input logic [31:0] addr, input int zeros);
        repeat (zeros) send_byte(8'h00);     // Resync bytes
        send_frame(OP_ADDR0, addr[7:0]);
        send_frame(OP_ADDR1, addr[15:8]);
        send_frame(OP_ADDR2, addr[23:16]);
        send_frame(OP_ADDR3, addr[31:24]);
        last_addr = addr;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] mask, input int zeros);
        logic [ADDR_WORDS_LOG2-1:0] idx;
        idx = addr[ADDR_WORDS_LOG2+1:2];
        load_address(addr, zeros);
        send_frame(OP_WDATA0, data[7:0]);
        send_frame(OP_WDATA1, data[15:8]);
        send_frame(OP_WDATA2, data[23:16]);
        send_frame(OP_WDATA3, data[31:24]);
        send_frame(OP_MASK, {4'h0, mask});
        send_frame(OP_MEM_WRITE, 8'h00);
        for (int b = 0; b < 4; b++)
            if (mask[b])
                shadow[idx][8*b +: 8] = data[8*b +: 8];
    endtask

    task automatic read_back(input logic [ADDR_WORDS_LOG2-1:0] idx);
        send_frame(OP_MEM_READ, 8'h00);
        for (int b = 0; b < 4 && timeouts == 0; b++)
            request_byte(b, shadow[idx][8*b +: 8]);
    endtask

    task automatic read_word(input logic [31:0] addr, input int zeros);
        load_address(addr, zeros);
        read_back(addr[ADDR_WORDS_LOG2+1:2]);
    endtask

    // Data register differs from the word at the held address, so a stray
    // write or address load shows up in the readback
    task automatic send_garbage(input logic [7:0] opcode, input logic [7:0] operand,
                                input int zeros);
        logic [ADDR_WORDS_LOG2-1:0] idx;
        logic [31:0]                inv;
        idx = last_addr[ADDR_WORDS_LOG2+1:2];
        inv = ~shadow[idx];
        send_frame(OP_WDATA0, inv[7:0]);
        send_frame(OP_WDATA1, inv[15:8]);
        send_frame(OP_WDATA2, inv[23:16]);
        send_frame(OP_WDATA3, inv[31:24]);
        send_frame(OP_MASK, 8'h0f);
        repeat (zeros) send_byte(8'h00);
        send_frame(opcode, operand);
        read_back(idx);
    endtask

    // Line must idle high whenever no byte is requested
    always @(negedge clk) begin
        if (reset_n && !tx_expected && !txd_reported && uart_txd !== 1'b1) begin
            txd_reported = 1'b1;
            check_bit("uart_txd", uart_txd, 1'b1);
        end
    end

    initial begin
        int          p;
        int          zeros;
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  mask;
        clk = 1'b0;
        reset_n = 1'b0;
        uart_rxd = 1'b1;
        tx_expected = 1'b0;
        txd_reported = 1'b0;
        last_addr = '0;
        seed = 32'he2f2;
        checks = 0;
        value_errors = 0;
        timeouts = 0;
        pattern_errors = 0;
        for (int i = 0; i < MAX_PATS * 5; i++)
            pat_mem[i] = '0;
        for (int i = 0; i < DEPTH; i++)
            shadow[i] = '0;
        $readmemh("verification/bridge_patterns.txt", pat_mem);
        repeat (10) @(posedge clk);
        #1 reset_n = 1'b1;
        repeat (5) @(posedge clk);
        p = 0;
        while (p < MAX_PATS && pat_mem[5*p] != 32'h0 && timeouts == 0) begin
            kind  = pat_mem[5*p];
            addr  = pat_mem[5*p+1];
            data  = pat_mem[5*p+2];
            mask  = pat_mem[5*p+3][3:0];
            zeros = int'(pat_mem[5*p+4]);
            case (kind)
                KIND_WRITE: write_word(addr, data, mask, zeros);
                KIND_READ:  read_word(addr, zeros);
                KIND_GARBAGE:           // Opcode in data[7:0], operand in data[15:8]
                    send_garbage(data[7:0], data[15:8], zeros);
                KIND_RANDOM: begin
                    addr = $random(seed);
                    data = $random(seed);
                    write_word(addr, data, mask, zeros);
                    read_word(addr, 0);
                end
                default: begin
                    pattern_errors++;
                    $display("Pattern %0d has an unknown kind 0x%0h", p, kind);
                end
            endcase
            p++;
        end
        $display("Checks: %0d, value errors: %0d, timeouts: %0d, pattern errors: %0d",
                 checks, value_errors, timeouts, pattern_errors);
        if (checks > 0 && value_errors == 0 && timeouts == 0 && pattern_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- verification/bridge_patterns.txt
// kind (1 write, 2 read, 3 unknown opcode, 4 random write and readback)
// byte_address data mask zero_prefix_count
2 00000010 00000000 0 0
1 00000010 a1b2c3d4 f 0
2 00000010 00000000 0 0
1 00000010 11223344 5 0
2 00000012 00000000 0 0
1 00000023 55667788 a 0
2 00000020 00000000 0 0
1 00000408 0badf00d f 2
2 00000008 00000000 0 1
3 00000000 0000aa30 0 0
3 00000000 000055ff 0 1
3 00000000 0000017f 0 0
2 00000010 00000000 0 0
4 00000000 00000000 f 0
4 00000000 00000000 3 1
2 000003fc 00000000 0 3
1 000003fe 12345678 c 0
2 000007fc 00000000 0 0

//--- files.f
rtl/uart_bridge_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/cmd_framer.sv
rtl/bridge_ctrl.sv
rtl/mem_port.sv
rtl/uart_mem_bridge.sv
verification/uart_mem_bridge_chk.sv
verification/tb_uart_mem_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -f files.f --top-module tb_uart_mem_bridge \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_uart_mem_bridge > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
